// ==== logic/column_bound_ram.sv ====
module column_bound_ram (
	input logic clk,
	input logic resetn,
	input logic we,
	input logic [overlay_pkg::x_w-1:0] waddr,
	input overlay_pkg::col_bound_t wdata,
	input logic re,
	input logic [overlay_pkg::x_w-1:0] raddr,
	output overlay_pkg::col_bound_t rdata
);
	import overlay_pkg::*;

	// top and bottom only, valid kept apart so reset can clear it at once
	logic [2*y_w-1:0] mem [col_depth];
	logic [col_depth-1:0] valid_bits;

	logic [x_w-1:0] raddr_q;
	col_bound_t rd_q;

	// host write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= {wdata.top, wdata.bottom};
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid_bits <= '0;
		end else if (we) begin
			valid_bits[waddr] <= wdata.valid;
		end
	end

	// cycle 1: address register
	always_ff @(posedge clk) begin
		if (re) begin
			raddr_q <= raddr;
		end
	end

	// cycle 2: array read
	always_ff @(posedge clk) begin
		rd_q.valid <= valid_bits[raddr_q];
		{rd_q.top, rd_q.bottom} <= mem[raddr_q];
	end

	// cycle 3: output register
	always_ff @(posedge clk) begin
		rdata <= rd_q;
	end

endmodule

// ==== logic/coord_tracker.sv ====
module coord_tracker (
	input logic clk,
	input logic resetn,
	input logic fsync,
	input logic accept,
	input overlay_pkg::in_beat_t beat,
	output overlay_pkg::coord_t coord
);
	import overlay_pkg::*;

	// position the next accepted beat will take
	logic [x_w-1:0] x_cnt;
	logic [y_w-1:0] y_cnt;

	logic [x_w-1:0] cur_x;
	logic [y_w-1:0] cur_y;

	// sof restarts both axes on the beat itself
	always_comb begin
		if (beat.sof) begin
			cur_x = '0;
			cur_y = '0;
		end else begin
			cur_x = x_cnt;
			cur_y = y_cnt;
		end
	end

	assign coord.x = cur_x;
	assign coord.y = cur_y;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (fsync) begin
			// known row even when sof goes missing
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (accept) begin
			if (beat.last) begin
				x_cnt <= '0;
				y_cnt <= cur_y + 1'b1;
			end else begin
				x_cnt <= cur_x + 1'b1;
				y_cnt <= cur_y;
			end
		end
	end

endmodule

// ==== logic/overlay_pipe.sv ====
module overlay_pipe (
	input logic clk,
	input logic resetn,
	input logic accept,
	input overlay_pkg::in_beat_t beat,
	input overlay_pkg::coord_t coord,
	input overlay_pkg::col_bound_t bound,
	input overlay_pkg::corner_t lft_geom,
	input overlay_pkg::corner_t rt_geom,
	input logic en_overlay,
	output logic wr,
	output overlay_pkg::out_beat_t wbeat
);
	import overlay_pkg::*;

	// stages 1..3 only wait for the column memory
	logic [3:1] vld_q;
	in_beat_t beat_q [1:3];
	coord_t coord_q [1:3];

	// stage 4
	logic vld_d4;
	in_beat_t beat_d4;
	region_e region_d4;

	region_e region_c;
	logic mark;

	// corner test for one pixel against both sides
	function automatic region_e classify(
		input coord_t c,
		input col_bound_t b,
		input corner_t l,
		input corner_t r
	);
		logic l_ok;
		logic r_ok;
		logic above_top;
		logic below_bot;
		logic l_top_x;
		logic l_bot_x;
		logic r_top_x;
		logic r_bot_x;

		l_ok = l.valid && b.valid;
		r_ok = r.valid && b.valid;

		// rows between the column limit and the corner row
		above_top = c.y < b.top;
		below_bot = c.y > b.bottom;

		l_top_x = (l.top_x < c.x) && (c.x <= l.edge_x);
		l_bot_x = (l.bot_x < c.x) && (c.x <= l.edge_x);
		r_top_x = (r.edge_x <= c.x) && (c.x < r.top_x);
		r_bot_x = (r.edge_x <= c.x) && (c.x < r.bot_x);

		if (l_ok && (l.top_y <= c.y) && above_top && l_top_x) begin
			return region_lt;
		end
		if (l_ok && (l.bot_y >= c.y) && below_bot && l_bot_x) begin
			return region_lb;
		end
		if (r_ok && (r.top_y <= c.y) && above_top && r_top_x) begin
			return region_rt;
		end
		if (r_ok && (r.bot_y >= c.y) && below_bot && r_bot_x) begin
			return region_rb;
		end
		return region_none;
	endfunction

	// valid chain
	always_ff @(posedge clk) begin
		if (!resetn) begin
			vld_q <= '0;
			vld_d4 <= 1'b0;
			wr <= 1'b0;
		end else begin
			vld_q <= {vld_q[2:1], accept};
			vld_d4 <= vld_q[3];
			wr <= vld_d4;
		end
	end

	// payload delay, memory result lines up after stage 3
	always_ff @(posedge clk) begin
		beat_q[1] <= beat;
		coord_q[1] <= coord;
		for (int i = 2; i <= 3; i++) begin
			beat_q[i] <= beat_q[i-1];
			coord_q[i] <= coord_q[i-1];
		end
	end

	assign region_c = classify(coord_q[3], bound, lft_geom, rt_geom);

	// stage 4
	always_ff @(posedge clk) begin
		beat_d4 <= beat_q[3];
		region_d4 <= region_c;
	end

	assign mark = en_overlay && (region_d4 != region_none);

	// stage 5, paint or replicate the grey byte
	always_ff @(posedge clk) begin
		wbeat.sof <= beat_d4.sof;
		wbeat.last <= beat_d4.last;
		if (mark) begin
			wbeat.data <= mark_value;
		end else begin
			wbeat.data <= {3{beat_d4.data}};
		end
	end

endmodule

// ==== logic/overlay_pkg.sv ====
package overlay_pkg;

	// pixel and image geometry
	localparam int ch_w = 8;
	localparam int x_w = 12;
	localparam int y_w = 12;
	localparam int out_w = 3 * ch_w;
	localparam int col_depth = 1 << x_w;

	// colour painted into corner pixels
	localparam logic [out_w-1:0] mark_value = 24'h00ff00;

	// accept to fifo write
	localparam int pipe_depth = 5;

	localparam int fifo_aw = 4;
	localparam int fifo_depth = 1 << fifo_aw;
	// room left for every beat still in the pipe when ready drops
	localparam int fifo_af_th = fifo_depth - pipe_depth - 1;

	typedef struct packed {
		logic [ch_w-1:0] data;
		logic sof;
		logic last;
	} in_beat_t;

	typedef struct packed {
		logic [x_w-1:0] x;
		logic [y_w-1:0] y;
	} coord_t;

	// outer limits of one column
	typedef struct packed {
		logic valid;
		logic [y_w-1:0] top;
		logic [y_w-1:0] bottom;
	} col_bound_t;

	typedef struct packed {
		logic valid;
		logic [x_w-1:0] edge_x;
		logic [x_w-1:0] top_x;
		logic [y_w-1:0] top_y;
		logic [x_w-1:0] bot_x;
		logic [y_w-1:0] bot_y;
	} corner_t;

	typedef struct packed {
		logic [out_w-1:0] data;
		logic sof;
		logic last;
	} out_beat_t;

	typedef enum logic [2:0] {
		region_none,
		region_lt,
		region_lb,
		region_rt,
		region_rb
	} region_e;

endpackage

// ==== logic/overlay_top.sv ====
module overlay_top (
	input logic clk,
	input logic resetn,
	input logic fsync,
	input logic en_overlay,
	input logic bound_we,
	input logic [overlay_pkg::x_w-1:0] bound_addr,
	input overlay_pkg::col_bound_t bound_wdata,
	input overlay_pkg::corner_t lft_geom,
	input overlay_pkg::corner_t rt_geom,
	input logic s_valid,
	input logic [overlay_pkg::ch_w-1:0] s_data,
	input logic s_sof,
	input logic s_last,
	output logic s_ready,
	output logic m_valid,
	output logic [overlay_pkg::out_w-1:0] m_data,
	output logic m_sof,
	output logic m_last,
	input logic m_ready
);
	import overlay_pkg::*;

	logic accept;
	logic almost_full;
	logic wr;
	in_beat_t in_beat;
	coord_t coord;
	col_bound_t bound;
	out_beat_t wbeat;
	out_beat_t m_beat;

	// no skid buffer, the fifo threshold covers the pipe
	assign s_ready = !almost_full;
	assign accept = s_valid && s_ready;

	assign in_beat.data = s_data;
	assign in_beat.sof = s_sof;
	assign in_beat.last = s_last;

	assign m_data = m_beat.data;
	assign m_sof = m_beat.sof;
	assign m_last = m_beat.last;

	coord_tracker u_tracker (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.accept(accept),
		.beat(in_beat),
		.coord(coord)
	);

	column_bound_ram u_bound_ram (
		.clk(clk),
		.resetn(resetn),
		.we(bound_we),
		.waddr(bound_addr),
		.wdata(bound_wdata),
		.re(accept),
		.raddr(coord.x),
		.rdata(bound)
	);

	overlay_pipe u_pipe (
		.clk(clk),
		.resetn(resetn),
		.accept(accept),
		.beat(in_beat),
		.coord(coord),
		.bound(bound),
		.lft_geom(lft_geom),
		.rt_geom(rt_geom),
		.en_overlay(en_overlay),
		.wr(wr),
		.wbeat(wbeat)
	);

	stream_fifo u_fifo (
		.clk(clk),
		.resetn(resetn),
		.wr(wr),
		.wbeat(wbeat),
		.almost_full(almost_full),
		.m_valid(m_valid),
		.m_beat(m_beat),
		.m_ready(m_ready)
	);

endmodule

// ==== logic/stream_fifo.sv ====
module stream_fifo (
	input logic clk,
	input logic resetn,
	input logic wr,
	input overlay_pkg::out_beat_t wbeat,
	output logic almost_full,
	output logic m_valid,
	output overlay_pkg::out_beat_t m_beat,
	input logic m_ready
);
	import overlay_pkg::*;

	out_beat_t mem [fifo_depth];

	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	logic [fifo_aw:0] count;

	logic full;
	logic empty;
	logic push;
	logic pop;
	// holds off input for the first cycle out of reset
	logic armed;

	assign full = (count == fifo_depth);
	assign empty = (count == '0);
	assign push = wr && !full;
	// refill the output register when it is free or leaving
	assign pop = !empty && (!m_valid || m_ready);

	assign almost_full = !armed || (count >= fifo_af_th);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wbeat;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// output register
	always_ff @(posedge clk) begin
		if (pop) begin
			m_beat <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_valid <= 1'b0;
		end else if (pop) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

endmodule

// ==== sim.f ====
logic/overlay_pkg.sv
logic/coord_tracker.sv
logic/column_bound_ram.sv
logic/overlay_pipe.sv
logic/stream_fifo.sv
logic/overlay_top.sv
sim/overlay_props.sv
sim/overlay_tb.sv

// ==== sim/overlay_props.sv ====
module overlay_props (
	input logic clk,
	input logic resetn,
	input logic s_ready,
	input logic m_valid,
	input logic m_ready,
	input logic [overlay_pkg::out_w-1:0] m_data,
	input logic m_sof,
	input logic m_last,
	input logic fifo_wr,
	input logic fifo_full
);

	// number of failed properties so far
	int fail_count = 0;

	// held beat is frozen under back-pressure
	hold_beat: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> $stable({m_data, m_sof, m_last}))
		else begin
			$error("output beat changed while waiting for m_ready");
			fail_count++;
		end

	hold_valid: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid)
		else begin
			$error("m_valid dropped before the beat was taken");
			fail_count++;
		end

	no_overflow: assert property (@(posedge clk) disable iff (!resetn)
		!(fifo_wr && fifo_full))
		else begin
			$error("pipeline wrote into a full output FIFO");
			fail_count++;
		end

	ready_low_in_reset: assert property (@(posedge clk) !resetn |=> !s_ready)
		else begin
			$error("s_ready high during or right after reset");
			fail_count++;
		end

endmodule

bind overlay_top overlay_props u_props (
	.clk(clk),
	.resetn(resetn),
	.s_ready(s_ready),
	.m_valid(m_valid),
	.m_ready(m_ready),
	.m_data(m_data),
	.m_sof(m_sof),
	.m_last(m_last),
	.fifo_wr(wr),
	.fifo_full(u_fifo.full)
);

// ==== sim/overlay_tb.sv ====
module overlay_tb;
	import overlay_pkg::*;

	localparam int frame_w = 32;
	localparam int frame_h = 12;
	localparam int max_wait = 200;

	logic clk = 1'b0;
	logic resetn, fsync, en_overlay, bound_we;
	logic [x_w-1:0] bound_addr;
	col_bound_t bound_wdata;
	corner_t lft_geom, rt_geom;
	logic s_valid, s_sof, s_last, s_ready;
	logic [ch_w-1:0] s_data;
	logic m_valid, m_sof, m_last, m_ready;
	logic [out_w-1:0] m_data;

	integer seed = 32'hb6a97fa6;
	// reference copy of the column memory, only the frame columns
	col_bound_t bounds [frame_w];
	out_beat_t exp_q [$];
	out_beat_t model_beat;
	int mx, my, accepted, marked;

	overlay_top uut (.*);

	always #4 clk = ~clk;

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// corner rule: between corner row and column limit, between corner x and edge
	function automatic logic in_corner(input int x, input int y);
		logic hit;
		hit = 1'b0;
		if (bounds[x].valid && lft_geom.valid && x <= lft_geom.edge_x) begin
			hit |= y >= lft_geom.top_y && y < bounds[x].top && x > lft_geom.top_x;
			hit |= y <= lft_geom.bot_y && y > bounds[x].bottom && x > lft_geom.bot_x;
		end
		if (bounds[x].valid && rt_geom.valid && x >= rt_geom.edge_x) begin
			hit |= y >= rt_geom.top_y && y < bounds[x].top && x < rt_geom.top_x;
			hit |= y <= rt_geom.bot_y && y > bounds[x].bottom && x < rt_geom.bot_x;
		end
		return hit;
	endfunction

	task automatic fail_now(input string why);
		$display("[ERROR] %s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_now($sformatf("%s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// every input change happens one unit after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
		m_ready = rand_below(4) != 0;
	endtask

	task automatic load_bounds();
		for (int c = 0; c < frame_w; c++) begin
			bounds[c].valid = rand_below(4) != 0;
			bounds[c].top = 2 + rand_below(5);
			bounds[c].bottom = 5 + rand_below(5);
			bound_we = 1'b1;
			bound_addr = c;
			bound_wdata = bounds[c];
			next_cycle();
		end
		bound_we = 1'b0;
	endtask

	task automatic pick_geometry();
		lft_geom.valid = rand_below(4) != 0;
		lft_geom.edge_x = 6 + rand_below(8);
		lft_geom.top_x = rand_below(4);
		lft_geom.top_y = rand_below(3);
		lft_geom.bot_x = rand_below(4);
		lft_geom.bot_y = 9 + rand_below(3);
		rt_geom.valid = rand_below(4) != 0;
		rt_geom.edge_x = 18 + rand_below(8);
		rt_geom.top_x = 26 + rand_below(7);
		rt_geom.top_y = rand_below(3);
		rt_geom.bot_x = 26 + rand_below(7);
		rt_geom.bot_y = 9 + rand_below(3);
	endtask

	task automatic send_beat(input logic [ch_w-1:0] data, input logic sof, input logic last);
		int waited;
		waited = 0;
		if (rand_below(3) == 0) begin
			repeat (1 + rand_below(3)) next_cycle();
		end
		s_valid = 1'b1;
		s_data = data;
		s_sof = sof;
		s_last = last;
		while (!s_ready) begin
			next_cycle();
			waited++;
			if (waited > max_wait) fail_now("input beat was never accepted, s_ready stuck low");
		end
		next_cycle();
		s_valid = 1'b0;
	endtask

	task automatic send_frame(input logic with_sof);
		for (int y = 0; y < frame_h; y++) begin
			for (int x = 0; x < frame_w; x++) begin
				send_beat(rand_below(256), with_sof && x == 0 && y == 0, x == frame_w - 1);
			end
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			next_cycle();
			waited++;
			if (waited > max_wait) fail_now("output stream did not drain in time");
		end
	endtask

	// model and output compare, sampled mid-cycle
	always @(negedge clk) begin
		if (uut.u_props.fail_count != 0) fail_now("a protocol assertion on the DUT failed");
		if (resetn) begin
			if (fsync) begin
				mx = 0;
				my = 0;
			end else if (s_valid && s_ready) begin
				if (s_sof) begin
					mx = 0;
					my = 0;
				end
				model_beat.sof = s_sof;
				model_beat.last = s_last;
				model_beat.data = {3{s_data}};
				if (en_overlay && in_corner(mx, my)) begin
					model_beat.data = mark_value;
					marked++;
				end
				exp_q.push_back(model_beat);
				accepted++;
				mx = s_last ? 0 : mx + 1;
				my = s_last ? my + 1 : my;
			end
			if (m_valid && accepted == 0) fail_now("m_valid went high before any beat was accepted");
			if (m_valid && m_ready) begin
				if (exp_q.size() == 0) fail_now("output beat arrived with no matching input beat");
				check("output beat", exp_q.pop_front(), {m_data, m_sof, m_last});
			end
		end
	end

	initial begin
		resetn = 1'b0;
		{fsync, en_overlay, bound_we, s_valid, s_sof, s_last, m_ready} = '0;
		bound_addr = '0;
		bound_wdata = '0;
		lft_geom = '0;
		rt_geom = '0;
		s_data = '0;
		{mx, my, accepted, marked} = '0;
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;
		check("m_valid after reset", 1'b0, m_valid);
		load_bounds();
		// phase 0 passes pixels through, later phases paint corners
		for (int phase = 0; phase < 4; phase++) begin
			en_overlay = phase != 0;
			pick_geometry();
			if (phase == 2) load_bounds();
			for (int f = 0; f < 2; f++) begin
				fsync = 1'b1;
				next_cycle();
				fsync = 1'b0;
				send_frame(rand_below(4) != 0);
			end
			wait_drain();
		end
		// let any stray extra beat surface
		repeat (20) next_cycle();
		$display("%0d beats compared, %0d painted", accepted, marked);
		if (exp_q.size() != 0 || m_valid) begin
			fail_now("output stream still busy after every input beat was matched");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule
